// ==== rtl/ccip_shim_pkg.sv ====
`default_nettype none

package ccip_shim_pkg;

    // Read request header is one plain word
    localparam int req_hdr_w = 32;

    // Line count minus one, in the low bits
    localparam int req_cl_len_lsb = 0;
    localparam int req_cl_len_w = 2;

    // 8-bit tag right above the line count
    // Address takes the remaining upper 22 bits
    localparam int req_mdata_lsb = 2;

    // Receive channel widths
    localparam int rx_hdr_w = 16;
    localparam int cl_data_w = 64;

    // Queue depths as log2 of the entry count
    localparam int req_depth_radix = 4;
    localparam int rsp_depth_radix = 5;

    // Requests the AFU may still issue after it sees almost-full
    localparam int alm_full_threshold = 2;

    // Outstanding lines allowed before almost-full rises
    // Eight per late request, not four, leaves room for MMIO beats
    // and for AFU reaction delay
    localparam int credit_limit = (2 ** rsp_depth_radix) - 8 * alm_full_threshold;

    // Zero or negative size here stops elaboration
    // Means the response queue is too shallow for the threshold
    typedef logic t_credit_limit_check [credit_limit];

    // Credit counter holds up to twice the response queue size
    localparam int cnt_w = rsp_depth_radix + 1;

    // One response queue entry: header, data and three kind bits
    localparam int rsp_entry_w = rx_hdr_w + cl_data_w + 3;

    // Receive header, read either as memory response or MMIO request
    typedef union packed {
        // Memory read response view
        struct packed {
            logic [3:0] rsp_type;
            // Set when one beat stands for several lines
            logic       cl_packed;
            logic [1:0] cl_num;
            logic [8:0] mdata;
        } mem;
        // MMIO read or write request view
        struct packed {
            logic [7:0] tid;
            logic [7:0] address;
        } mmio;
    } t_c0_rx_hdr;

endpackage

`default_nettype wire

// ==== rtl/c0_rx_if.sv ====
`default_nettype none

interface c0_rx_if;
    import ccip_shim_pkg::*;

    // Beat kind, at most one set per cycle
    logic                 rsp_valid;
    logic                 mmio_rd_valid;
    logic                 mmio_wr_valid;

    // Header decoded by kind, data meaningful for responses and MMIO writes
    t_c0_rx_hdr           hdr;
    logic [cl_data_w-1:0] data;

    // Response queue drives the beat toward the AFU
    modport source (
        output rsp_valid,
        output mmio_rd_valid,
        output mmio_wr_valid,
        output hdr,
        output data
    );

    // Credit tracker watches the same beat
    modport monitor (
        input rsp_valid,
        input mmio_rd_valid,
        input mmio_wr_valid,
        input hdr,
        input data
    );

endinterface

`default_nettype wire

// ==== rtl/sync_fifo.sv ====
`default_nettype none

module sync_fifo
  #(
    parameter int data_w = 8,
    parameter int depth_radix = 4
    )
   (
    input  logic                   afu_clk,
    input  logic                   afu_softreset,
    input  logic                   wr_en,
    input  logic [data_w-1:0]      wr_data,
    input  logic                   rd_en,
    output logic [data_w-1:0]      rd_data,
    output logic                   empty,
    output logic                   full,
    output logic [depth_radix-1:0] fill
    );

    // Storage, 2**depth_radix entries
    logic [data_w-1:0]    mem [2 ** depth_radix];

    // Pointers carry one extra wrap bit
    logic [depth_radix:0] wr_ptr;
    logic [depth_radix:0] rd_ptr;
    logic [depth_radix:0] used;
    logic                 wr_fire;
    logic                 rd_fire;

    // Occupancy from pointer distance
    assign used = wr_ptr - rd_ptr;
    assign empty = (used == '0);
    // Only the full count reaches the wrap bit
    assign full = used[depth_radix];

    // Full saturates so the top bit stays set at the last entry
    assign fill = full ? '1 : used[depth_radix-1:0];

    // Writes into a full FIFO are dropped
    assign wr_fire = wr_en && !full;
    assign rd_fire = rd_en && !empty;

    always_ff @(posedge afu_clk)
    begin
        if (afu_softreset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (wr_fire)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Write port
    always_ff @(posedge afu_clk)
    begin
        if (wr_fire)
        begin
            mem[wr_ptr[depth_radix-1:0]] <= wr_data;
        end
    end

    // Registered read, data valid the cycle after rd_en
    always_ff @(posedge afu_clk)
    begin
        if (rd_fire)
        begin
            rd_data <= mem[rd_ptr[depth_radix-1:0]];
        end
    end

    // Owners pop only while the FIFO holds data
    a_no_read_empty: assert property (@(posedge afu_clk) disable iff (afu_softreset)
        rd_en |-> !empty);

endmodule

`default_nettype wire

// ==== rtl/c0_req_queue.sv ====
`default_nettype none

module c0_req_queue
   (
    input  logic                                      afu_clk,
    input  logic                                      afu_softreset,
    input  logic                                      c0_req_valid,
    input  logic [ccip_shim_pkg::req_hdr_w-1:0]       c0_req_hdr,
    input  logic                                      host_alm_full,
    output logic                                      host_req_valid,
    output logic [ccip_shim_pkg::req_hdr_w-1:0]       host_req_hdr,
    output logic [ccip_shim_pkg::req_depth_radix-1:0] req_fill,
    output logic                                      req_overflow
    );
    import ccip_shim_pkg::*;

    // AFU side input register
    logic                 req_valid_q;
    logic [req_hdr_w-1:0] req_hdr_q;

    // FIFO read side
    logic [req_hdr_w-1:0] fifo_dout;
    logic                 fifo_empty;
    logic                 fifo_full;
    logic                 pop;
    logic                 pop_q;

    always_ff @(posedge afu_clk)
    begin
        if (afu_softreset)
        begin
            req_valid_q <= 1'b0;
        end
        else
        begin
            req_valid_q <= c0_req_valid;
        end
    end

    always_ff @(posedge afu_clk)
    begin
        req_hdr_q <= c0_req_hdr;
    end

    sync_fifo
      #(
        .data_w(req_hdr_w),
        .depth_radix(req_depth_radix)
        )
      req_fifo
       (
        .afu_clk(afu_clk),
        .afu_softreset(afu_softreset),
        .wr_en(req_valid_q),
        .wr_data(req_hdr_q),
        .rd_en(pop),
        .rd_data(fifo_dout),
        .empty(fifo_empty),
        .full(fifo_full),
        .fill(req_fill)
        );

    // Forward while the host still takes requests
    assign pop = !fifo_empty && !host_alm_full;

    // Popped entry shows on the FIFO output one cycle later
    always_ff @(posedge afu_clk)
    begin
        if (afu_softreset)
        begin
            pop_q <= 1'b0;
            host_req_valid <= 1'b0;
        end
        else
        begin
            pop_q <= pop;
            host_req_valid <= pop_q;
        end
    end

    // Host side output register
    always_ff @(posedge afu_clk)
    begin
        host_req_hdr <= fifo_dout;
    end

    // Sticky drop flag, AFU ignored almost-full
    always_ff @(posedge afu_clk)
    begin
        if (afu_softreset)
        begin
            req_overflow <= 1'b0;
        end
        else
        begin
            req_overflow <= req_overflow || (req_valid_q && fifo_full);
        end
    end

    // Two cycles of host almost-full drain the popped request out of the pipe
    a_host_backpressure: assert property (@(posedge afu_clk) disable iff (afu_softreset)
        host_alm_full ##1 host_alm_full |=> !host_req_valid);

endmodule

`default_nettype wire

// ==== rtl/c0_credit_tracker.sv ====
`default_nettype none

module c0_credit_tracker
   (
    input  logic                                      afu_clk,
    input  logic                                      afu_softreset,
    input  logic                                      c0_req_valid,
    input  logic [ccip_shim_pkg::req_hdr_w-1:0]       c0_req_hdr,
    input  logic [ccip_shim_pkg::req_depth_radix-1:0] req_fill,
    c0_rx_if.monitor                                  rx,
    output logic                                      c0_tx_alm_full
    );
    import ccip_shim_pkg::*;

    logic [req_cl_len_w-1:0] req_cl_len;
    // Lines added and returned this cycle
    logic [cnt_w-1:0]        inc;
    logic [cnt_w-1:0]        dec;
    // Lines requested but not yet returned
    logic [cnt_w-1:0]        cnt;

    assign req_cl_len = c0_req_hdr[req_cl_len_lsb +: req_cl_len_w];

    // Request adds its full line count
    always_comb
    begin
        inc = '0;
        if (c0_req_valid)
        begin
            inc = cnt_w'(req_cl_len) + 1'b1;
        end
    end

    // Memory response returns one line, or cl_num+1 when packed
    // MMIO beats never touch the count
    always_comb
    begin
        dec = '0;
        if (rx.rsp_valid)
        begin
            if (rx.hdr.mem.cl_packed)
            begin
                dec = cnt_w'(rx.hdr.mem.cl_num) + 1'b1;
            end
            else
            begin
                dec = cnt_w'(1);
            end
        end
    end

    always_ff @(posedge afu_clk)
    begin
        if (afu_softreset)
        begin
            cnt <= '0;
        end
        else
        begin
            cnt <= cnt + inc - dec;
        end
    end

    // Request queue half full, or too many lines in flight
    always_ff @(posedge afu_clk)
    begin
        if (afu_softreset)
        begin
            c0_tx_alm_full <= 1'b0;
        end
        else
        begin
            c0_tx_alm_full <= req_fill[req_depth_radix-1] ||
                              (cnt > cnt_w'(credit_limit));
        end
    end

    // Host never returns more lines than the AFU requested
    a_cnt_no_underflow: assert property (@(posedge afu_clk) disable iff (afu_softreset)
        ((cnt_w+1)'(cnt) + (cnt_w+1)'(inc)) >= (cnt_w+1)'(dec));

endmodule

`default_nettype wire

// ==== rtl/c0_rsp_queue.sv ====
`default_nettype none

module c0_rsp_queue
   (
    input  logic                                afu_clk,
    input  logic                                afu_softreset,
    input  logic                                host_rsp_valid,
    input  logic                                host_mmio_rd_valid,
    input  logic                                host_mmio_wr_valid,
    input  logic [ccip_shim_pkg::rx_hdr_w-1:0]  host_rx_hdr,
    input  logic [ccip_shim_pkg::cl_data_w-1:0] host_rx_data,
    c0_rx_if.source                             rx,
    output logic                                rsp_overflow
    );
    import ccip_shim_pkg::*;

    // Host side input register
    logic                   rsp_valid_q;
    logic                   mmio_rd_valid_q;
    logic                   mmio_wr_valid_q;
    logic [rx_hdr_w-1:0]    rx_hdr_q;
    logic [cl_data_w-1:0]   rx_data_q;
    logic                   beat_q;

    // FIFO entry packing
    logic [rsp_entry_w-1:0] fifo_din;
    logic [rsp_entry_w-1:0] fifo_dout;
    logic                   fifo_empty;
    logic                   fifo_full;
    logic                   pop;
    logic                   pop_q;

    // Unpacked FIFO output
    logic [rx_hdr_w-1:0]    out_hdr;
    logic [cl_data_w-1:0]   out_data;
    logic                   out_rsp;
    logic                   out_mmio_rd;
    logic                   out_mmio_wr;

    always_ff @(posedge afu_clk)
    begin
        if (afu_softreset)
        begin
            rsp_valid_q <= 1'b0;
            mmio_rd_valid_q <= 1'b0;
            mmio_wr_valid_q <= 1'b0;
        end
        else
        begin
            rsp_valid_q <= host_rsp_valid;
            mmio_rd_valid_q <= host_mmio_rd_valid;
            mmio_wr_valid_q <= host_mmio_wr_valid;
        end
    end

    always_ff @(posedge afu_clk)
    begin
        rx_hdr_q <= host_rx_hdr;
        rx_data_q <= host_rx_data;
    end

    // Any kind of beat takes one entry
    assign beat_q = rsp_valid_q || mmio_rd_valid_q || mmio_wr_valid_q;
    assign fifo_din = {rx_hdr_q, rx_data_q, rsp_valid_q, mmio_rd_valid_q, mmio_wr_valid_q};

    sync_fifo
      #(
        .data_w(rsp_entry_w),
        .depth_radix(rsp_depth_radix)
        )
      rsp_fifo
       (
        .afu_clk(afu_clk),
        .afu_softreset(afu_softreset),
        .wr_en(beat_q),
        .wr_data(fifo_din),
        .rd_en(pop),
        .rd_data(fifo_dout),
        .empty(fifo_empty),
        .full(fifo_full),
        .fill()
        );

    // No back-pressure toward the AFU
    assign pop = !fifo_empty;
    assign {out_hdr, out_data, out_rsp, out_mmio_rd, out_mmio_wr} = fifo_dout;

    // Kind bits count only in the cycle after a pop
    always_ff @(posedge afu_clk)
    begin
        if (afu_softreset)
        begin
            pop_q <= 1'b0;
            rx.rsp_valid <= 1'b0;
            rx.mmio_rd_valid <= 1'b0;
            rx.mmio_wr_valid <= 1'b0;
        end
        else
        begin
            pop_q <= pop;
            rx.rsp_valid <= pop_q && out_rsp;
            rx.mmio_rd_valid <= pop_q && out_mmio_rd;
            rx.mmio_wr_valid <= pop_q && out_mmio_wr;
        end
    end

    // AFU side payload register
    always_ff @(posedge afu_clk)
    begin
        rx.hdr <= out_hdr;
        rx.data <= out_data;
    end

    // Sticky drop flag, host outran the credits
    always_ff @(posedge afu_clk)
    begin
        if (afu_softreset)
        begin
            rsp_overflow <= 1'b0;
        end
        else
        begin
            rsp_overflow <= rsp_overflow || (beat_q && fifo_full);
        end
    end

    // Host sends one kind of beat per cycle
    a_one_kind: assert property (@(posedge afu_clk) disable iff (afu_softreset)
        $onehot0({host_rsp_valid, host_mmio_rd_valid, host_mmio_wr_valid}));

endmodule

`default_nettype wire

// ==== rtl/ccip_c0_shim.sv ====
`default_nettype none

module ccip_c0_shim
   (
    input  logic                                afu_clk,
    input  logic                                afu_softreset,

    // AFU read requests
    input  logic                                c0_req_valid,
    input  logic [ccip_shim_pkg::req_hdr_w-1:0] c0_req_hdr,
    output logic                                c0_tx_alm_full,

    // Read requests toward the host
    output logic                                host_req_valid,
    output logic [ccip_shim_pkg::req_hdr_w-1:0] host_req_hdr,
    input  logic                                host_alm_full,

    // Receive beats from the host
    input  logic                                host_rsp_valid,
    input  logic                                host_mmio_rd_valid,
    input  logic                                host_mmio_wr_valid,
    input  logic [ccip_shim_pkg::rx_hdr_w-1:0]  host_rx_hdr,
    input  logic [ccip_shim_pkg::cl_data_w-1:0] host_rx_data,

    // Receive beats toward the AFU
    output logic                                afu_rsp_valid,
    output logic                                afu_mmio_rd_valid,
    output logic                                afu_mmio_wr_valid,
    output logic [ccip_shim_pkg::rx_hdr_w-1:0]  afu_rx_hdr,
    output logic [ccip_shim_pkg::cl_data_w-1:0] afu_rx_data,

    // Bit 0 request FIFO drop, bit 1 response FIFO drop
    output logic [1:0]                          shim_error
    );

    logic [ccip_shim_pkg::req_depth_radix-1:0] req_fill;
    logic                                      req_overflow;
    logic                                      rsp_overflow;

    // Beat shared by response queue and credit tracker
    c0_rx_if rx ();

    c0_req_queue req_queue
       (
        .afu_clk(afu_clk),
        .afu_softreset(afu_softreset),
        .c0_req_valid(c0_req_valid),
        .c0_req_hdr(c0_req_hdr),
        .host_alm_full(host_alm_full),
        .host_req_valid(host_req_valid),
        .host_req_hdr(host_req_hdr),
        .req_fill(req_fill),
        .req_overflow(req_overflow)
        );

    c0_credit_tracker credit_tracker
       (
        .afu_clk(afu_clk),
        .afu_softreset(afu_softreset),
        .c0_req_valid(c0_req_valid),
        .c0_req_hdr(c0_req_hdr),
        .req_fill(req_fill),
        .rx(rx),
        .c0_tx_alm_full(c0_tx_alm_full)
        );

    c0_rsp_queue rsp_queue
       (
        .afu_clk(afu_clk),
        .afu_softreset(afu_softreset),
        .host_rsp_valid(host_rsp_valid),
        .host_mmio_rd_valid(host_mmio_rd_valid),
        .host_mmio_wr_valid(host_mmio_wr_valid),
        .host_rx_hdr(host_rx_hdr),
        .host_rx_data(host_rx_data),
        .rx(rx),
        .rsp_overflow(rsp_overflow)
        );

    // Spread the beat onto the AFU ports
    assign afu_rsp_valid = rx.rsp_valid;
    assign afu_mmio_rd_valid = rx.mmio_rd_valid;
    assign afu_mmio_wr_valid = rx.mmio_wr_valid;
    assign afu_rx_hdr = rx.hdr;
    assign afu_rx_data = rx.data;

    assign shim_error = {rsp_overflow, req_overflow};

endmodule

`default_nettype wire

// ==== testbench/tb_ccip_c0_shim.sv ====
`default_nettype none

module tb_ccip_c0_shim;
    import ccip_shim_pkg::*;

    // Table entry kinds
    localparam int k_req = 0;
    localparam int k_rsp = 1;
    localparam int k_mmio_rd = 2;
    localparam int k_mmio_wr = 3;
    localparam int k_host = 4;
    localparam int k_reset = 5;

    // Tag doubles as host level for k_host and cl_len as cl_num for responses
    typedef struct {
        int phase;
        int kind;
        int tag;
        int cl_len;
        int packed_bit;
        int hold;
    } t_entry;

    logic                 afu_clk;
    logic                 afu_softreset;
    logic                 c0_req_valid;
    logic [req_hdr_w-1:0] c0_req_hdr;
    logic                 c0_tx_alm_full;
    logic                 host_req_valid;
    logic [req_hdr_w-1:0] host_req_hdr;
    logic                 host_alm_full;
    logic                 host_rsp_valid;
    logic                 host_mmio_rd_valid;
    logic                 host_mmio_wr_valid;
    logic [rx_hdr_w-1:0]  host_rx_hdr;
    logic [cl_data_w-1:0] host_rx_data;
    logic                 afu_rsp_valid;
    logic                 afu_mmio_rd_valid;
    logic                 afu_mmio_wr_valid;
    logic [rx_hdr_w-1:0]  afu_rx_hdr;
    logic [cl_data_w-1:0] afu_rx_data;
    logic [1:0]           shim_error;

    t_entry               tbl[$];
    // Scoreboards with arrival cycle -1 where back-pressure leaves it open
    logic [req_hdr_w-1:0] exp_req_hdr[$];
    int                   exp_req_cyc[$];
    logic [rx_hdr_w-1:0]  exp_rx_hdr[$];
    logic [cl_data_w-1:0] exp_rx_data[$];
    logic [2:0]           exp_rx_vld[$];

    int                   cyc = 0;
    int                   cycle_limit = 1000000;
    int                   hold_cyc = 0;
    int                   host_hold = 0;
    int                   model_cnt = 0;
    logic                 model_ovf = 1'b0;
    int                   mismatch_count = 0;
    int                   other_count = 0;
    int                   cur_phase = 0;
    logic [15:0]          lfsr = 16'd20679;

    ccip_c0_shim ccip_c0_shim_inst (.*);

    initial
    begin
        afu_clk = 1'b0;
        forever #50 afu_clk = ~afu_clk;
    end

    always @(posedge afu_clk)
    begin
        cyc <= cyc + 1;
        if (cyc >= cycle_limit)
        begin
            $display("Timeout: run passed %0d cycles in phase %0d", cyc, cur_phase);
            $display("Regression failed");
            $finish;
        end
    end

    // Taps 16 14 13 11 with one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r = {r[62:0], fb};
        end
        return r;
    endfunction

    function automatic void add(input int phase, input int kind, input int tag,
                                input int cl_len, input int packed_bit, input int hold);
        t_entry e;
        e.phase = phase;
        e.kind = kind;
        e.tag = tag;
        e.cl_len = cl_len;
        e.packed_bit = packed_bit;
        e.hold = hold;
        tbl.push_back(e);
    endfunction

    // Host request monitor samples on the falling edge where outputs are stable
    always @(negedge afu_clk)
    begin
        if (host_req_valid && host_alm_full && (cyc >= hold_cyc + 2))
        begin
            $display("Request left toward the host while host almost-full was held");
            other_count++;
        end
        if (host_req_valid)
        begin
            if (exp_req_hdr.size() == 0)
            begin
                $display("Unexpected request toward the host in phase %0d", cur_phase);
                other_count++;
            end
            else
            begin
                if (host_req_hdr !== exp_req_hdr[0])
                begin
                    $display("MISMATCH host_req_hdr: expected %h, got %h",
                             exp_req_hdr[0], host_req_hdr);
                    mismatch_count++;
                end
                if ((exp_req_cyc[0] >= 0) && (cyc != exp_req_cyc[0]))
                begin
                    $display("Request arrived at cycle %0d instead of %0d",
                             cyc, exp_req_cyc[0]);
                    other_count++;
                end
                void'(exp_req_hdr.pop_front());
                void'(exp_req_cyc.pop_front());
            end
        end
    end

    // AFU receive monitor
    always @(negedge afu_clk)
    begin
        if (afu_rsp_valid || afu_mmio_rd_valid || afu_mmio_wr_valid)
        begin
            if (exp_rx_vld.size() == 0)
            begin
                $display("Unexpected beat toward the AFU in phase %0d", cur_phase);
                other_count++;
            end
            else
            begin
                if ({afu_rsp_valid, afu_mmio_rd_valid, afu_mmio_wr_valid} !== exp_rx_vld[0])
                begin
                    $display("MISMATCH afu valid bits: expected %h, got %h", exp_rx_vld[0],
                             {afu_rsp_valid, afu_mmio_rd_valid, afu_mmio_wr_valid});
                    mismatch_count++;
                end
                if (afu_rx_hdr !== exp_rx_hdr[0])
                begin
                    $display("MISMATCH afu_rx_hdr: expected %h, got %h",
                             exp_rx_hdr[0], afu_rx_hdr);
                    mismatch_count++;
                end
                if (afu_rx_data !== exp_rx_data[0])
                begin
                    $display("MISMATCH afu_rx_data: expected %h, got %h",
                             exp_rx_data[0], afu_rx_data);
                    mismatch_count++;
                end
                void'(exp_rx_vld.pop_front());
                void'(exp_rx_hdr.pop_front());
                void'(exp_rx_data.pop_front());
            end
        end
    end

    // Flags and scoreboards once the pipes went quiet
    // Backlog equals FIFO fill then
    task automatic check_settled();
        logic exp_alm;
        exp_alm = (exp_req_hdr.size() >= 8) || (model_cnt > credit_limit);
        if (c0_tx_alm_full !== exp_alm)
        begin
            $display("MISMATCH c0_tx_alm_full: expected %h, got %h", exp_alm, c0_tx_alm_full);
            mismatch_count++;
        end
        if (shim_error !== {1'b0, model_ovf})
        begin
            $display("MISMATCH shim_error: expected %h, got %h", {1'b0, model_ovf}, shim_error);
            mismatch_count++;
        end
        // A free host must have drained every request by now
        if ((host_hold == 0) && (exp_req_hdr.size() != 0))
        begin
            $display("%0d requests never reached the host in phase %0d",
                     exp_req_hdr.size(), cur_phase);
            other_count++;
        end
        if (exp_rx_vld.size() != 0)
        begin
            $display("%0d beats never reached the AFU in phase %0d",
                     exp_rx_vld.size(), cur_phase);
            other_count++;
        end
    endtask

    task automatic apply_entry(input t_entry e);
        logic [req_hdr_w-1:0] hdr;
        t_c0_rx_hdr           rx_hdr;
        logic [cl_data_w-1:0] data;
        logic                 timed;
        cur_phase = e.phase;
        case (e.kind)
            k_req:
            begin
                hdr = '0;
                hdr[req_cl_len_lsb +: req_cl_len_w] = req_cl_len_w'(e.cl_len);
                hdr[req_mdata_lsb +: 8] = 8'(e.tag);
                hdr[req_hdr_w-1 -: 22] = 22'(rand_bits(22));
                c0_req_valid = 1'b1;
                c0_req_hdr = hdr;
                // Credits count even a dropped request
                model_cnt += e.cl_len + 1;
                timed = (host_hold == 0);
                foreach (exp_req_cyc[i])
                begin
                    if (exp_req_cyc[i] < 0)
                    begin
                        timed = 1'b0;
                    end
                end
                if ((host_hold != 0) && (exp_req_hdr.size() >= 16))
                begin
                    model_ovf = 1'b1;
                end
                else
                begin
                    exp_req_hdr.push_back(hdr);
                    exp_req_cyc.push_back(timed ? cyc + 4 : -1);
                end
            end
            k_rsp:
            begin
                rx_hdr.mem.rsp_type = 4'h0;
                rx_hdr.mem.cl_packed = (e.packed_bit != 0);
                rx_hdr.mem.cl_num = 2'(e.cl_len);
                rx_hdr.mem.mdata = 9'(e.tag);
                data = rand_bits(64);
                host_rsp_valid = 1'b1;
                model_cnt -= (e.packed_bit != 0) ? e.cl_len + 1 : 1;
                exp_rx_vld.push_back(3'b100);
            end
            k_mmio_rd, k_mmio_wr:
            begin
                rx_hdr.mmio.tid = 8'(e.tag);
                rx_hdr.mmio.address = 8'(rand_bits(8));
                data = rand_bits(64);
                host_mmio_rd_valid = (e.kind == k_mmio_rd);
                host_mmio_wr_valid = (e.kind == k_mmio_wr);
                exp_rx_vld.push_back((e.kind == k_mmio_rd) ? 3'b010 : 3'b001);
            end
            k_host:
            begin
                // Hold starts only when almost-full rises
                if ((e.tag != 0) && !host_alm_full)
                begin
                    hold_cyc = cyc;
                end
                host_alm_full = (e.tag != 0);
                host_hold = e.tag;
            end
            default:
            begin
                afu_softreset = 1'b1;
                repeat (5) @(negedge afu_clk);
                afu_softreset = 1'b0;
                exp_req_hdr.delete();
                exp_req_cyc.delete();
                model_cnt = 0;
                model_ovf = 1'b0;
            end
        endcase
        if ((e.kind >= k_rsp) && (e.kind <= k_mmio_wr))
        begin
            host_rx_hdr = rx_hdr;
            host_rx_data = data;
            exp_rx_hdr.push_back(rx_hdr);
            exp_rx_data.push_back(data);
        end
        @(negedge afu_clk);
        c0_req_valid = 1'b0;
        host_rsp_valid = 1'b0;
        host_mmio_rd_valid = 1'b0;
        host_mmio_wr_valid = 1'b0;
        if (e.hold > 0)
        begin
            repeat (e.hold) @(negedge afu_clk);
            check_settled();
        end
    endtask

    initial
    begin
        afu_softreset = 1'b1;
        c0_req_valid = 1'b0;
        c0_req_hdr = '0;
        host_alm_full = 1'b0;
        host_rsp_valid = 1'b0;
        host_mmio_rd_valid = 1'b0;
        host_mmio_wr_valid = 1'b0;
        host_rx_hdr = '0;
        host_rx_data = '0;

        // Forwarding with a free host
        for (int i = 0; i < 6; i++)
        begin
            add(1, k_req, 16 + i, 0, 0, (i == 5) ? 6 : 0);
        end
        // Mixed receive beats returning six memory lines
        add(5, k_rsp, 1, 0, 0, 0);
        add(5, k_mmio_rd, 2, 0, 0, 0);
        add(5, k_rsp, 3, 0, 0, 0);
        add(5, k_mmio_wr, 4, 0, 0, 0);
        add(5, k_rsp, 5, 0, 0, 0);
        add(5, k_rsp, 6, 0, 0, 0);
        add(5, k_mmio_wr, 7, 0, 0, 0);
        add(5, k_rsp, 8, 0, 0, 0);
        add(5, k_rsp, 9, 0, 0, 6);
        // Host held off until fill reaches 8
        // Seven entries still leave almost-full low
        add(2, k_host, 1, 0, 0, 4);
        for (int i = 0; i < 8; i++)
        begin
            add(3, k_req, 32 + i, 0, 0, (i == 7) ? 6 : ((i == 6) ? 4 : 0));
        end
        add(3, k_host, 0, 0, 0, 14);
        add(3, k_rsp, 10, 3, 1, 0);
        add(3, k_rsp, 11, 3, 1, 6);
        // Twenty lines in flight and returned in uneven pieces
        for (int i = 0; i < 5; i++)
        begin
            add(4, k_req, 48 + i, 3, 0, (i == 4) ? 6 : 0);
        end
        add(4, k_rsp, 12, 1, 1, 6);
        add(4, k_rsp, 13, 3, 0, 6);
        add(4, k_mmio_rd, 14, 0, 0, 6);
        add(4, k_rsp, 15, 0, 1, 6);
        for (int i = 0; i < 4; i++)
        begin
            add(4, k_rsp, 16 + i, 3, 1, (i == 3) ? 6 : 0);
        end
        // Push past the request FIFO depth and clear by reset
        add(6, k_host, 1, 0, 0, 4);
        for (int i = 0; i < 20; i++)
        begin
            add(6, k_req, 64 + i, 0, 0, (i == 19) ? 6 : 0);
        end
        add(6, k_host, 1, 0, 0, 10);
        add(6, k_reset, 0, 0, 0, 6);
        add(6, k_host, 0, 0, 0, 6);

        cycle_limit = 40 * tbl.size() + 200;

        repeat (5) @(negedge afu_clk);
        afu_softreset = 1'b0;
        check_settled();

        foreach (tbl[i])
        begin
            apply_entry(tbl[i]);
        end
        repeat (10) @(negedge afu_clk);

        if ((exp_req_hdr.size() != 0) || (exp_rx_vld.size() != 0))
        begin
            $display("Expected traffic never arrived: %0d requests, %0d beats",
                     exp_req_hdr.size(), exp_rx_vld.size());
            other_count++;
        end

        $display("Mismatches: %0d, other errors: %0d", mismatch_count, other_count);
        if ((mismatch_count == 0) && (other_count == 0))
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== ccip_c0_shim.f ====
rtl/ccip_shim_pkg.sv
rtl/c0_rx_if.sv
rtl/sync_fifo.sv
rtl/c0_req_queue.sv
rtl/c0_credit_tracker.sv
rtl/c0_rsp_queue.sv
rtl/ccip_c0_shim.sv
testbench/tb_ccip_c0_shim.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the channel-0 shim regression with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_ccip_c0_shim \
    -Mdir obj_dir \
    -f ccip_c0_shim.f

./obj_dir/Vtb_ccip_c0_shim | tee sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0
